/* hdl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;
	localparam int aluOpWidth = 3;
	localparam int pcSourceWidth = 3;
	localparam int regSourceWidth = 3;
	localparam int regDstWidth = 2;
	localparam int aluSrcBWidth = 2;
	localparam int addrSourceWidth = 2;
	localparam int stepIndexWidth = 3;

	localparam logic [opcodeWidth-1:0] opRType = 6'h00;
	localparam logic [opcodeWidth-1:0] opJ = 6'h02;
	localparam logic [opcodeWidth-1:0] opJal = 6'h03;
	localparam logic [opcodeWidth-1:0] opBeq = 6'h04;
	localparam logic [opcodeWidth-1:0] opBne = 6'h05;
	localparam logic [opcodeWidth-1:0] opLui = 6'h0f;
	localparam logic [opcodeWidth-1:0] opLw = 6'h23;
	localparam logic [opcodeWidth-1:0] opSw = 6'h2b;

	localparam logic [functWidth-1:0] fnNop = 6'h00; // no shifts, so funct 0 is always nop
	localparam logic [functWidth-1:0] fnJr = 6'h08;
	localparam logic [functWidth-1:0] fnBreak = 6'h0d;
	localparam logic [functWidth-1:0] fnAdd = 6'h20;
	localparam logic [functWidth-1:0] fnSub = 6'h22;
	localparam logic [functWidth-1:0] fnAnd = 6'h24;
	localparam logic [functWidth-1:0] fnXor = 6'h26;
	localparam logic [functWidth-1:0] fnSlt = 6'h2a;

	localparam logic [aluOpWidth-1:0] aluPass = 3'd0;
	localparam logic [aluOpWidth-1:0] aluAdd = 3'd1;
	localparam logic [aluOpWidth-1:0] aluSub = 3'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 3'd3;
	localparam logic [aluOpWidth-1:0] aluXor = 3'd6;
	localparam logic [aluOpWidth-1:0] aluSlt = 3'd7;

	localparam logic [pcSourceWidth-1:0] pcFromAlu = 3'd0;
	localparam logic [pcSourceWidth-1:0] pcFromAluOut = 3'd1; // branch target
	localparam logic [pcSourceWidth-1:0] pcFromJump = 3'd2;
	localparam logic [pcSourceWidth-1:0] pcFromReg = 3'd3;

	localparam logic [regSourceWidth-1:0] srcAluOut = 3'd0;
	localparam logic [regSourceWidth-1:0] srcMemData = 3'd1;
	localparam logic [regSourceWidth-1:0] srcUpperImm = 3'd2;
	localparam logic [regSourceWidth-1:0] srcZero = 3'd3;
	localparam logic [regSourceWidth-1:0] srcOne = 3'd4;
	localparam logic [regSourceWidth-1:0] srcReturnAddr = 3'd6;

	localparam logic [regDstWidth-1:0] dstRt = 2'd0;
	localparam logic [regDstWidth-1:0] dstRd = 2'd1;
	localparam logic [regDstWidth-1:0] dstRa = 2'd2; // r31

	localparam logic [aluSrcBWidth-1:0] srcBReg = 2'd0;
	localparam logic [aluSrcBWidth-1:0] srcBFour = 2'd1;
	localparam logic [aluSrcBWidth-1:0] srcBImm = 2'd2;
	localparam logic [aluSrcBWidth-1:0] srcBBranch = 2'd3; // imm shifted left by two

	localparam logic [addrSourceWidth-1:0] addrFromPc = 2'd0;
	localparam logic [addrSourceWidth-1:0] addrFromAluOut = 2'd1;

	localparam int fetchSteps = 3;
	localparam int aluExecSteps = 2;
	localparam int sltExecSteps = 2;
	localparam int branchExecSteps = 1;
	localparam int lwExecSteps = 5;
	localparam int swExecSteps = 3;
	localparam int luiExecSteps = 1;
	localparam int jumpExecSteps = 1; // j and jr
	localparam int jalExecSteps = 2;
	localparam int nopExecSteps = 1;

	typedef struct packed {
		logic [opcodeWidth-1:0] opcode;
		logic [functWidth-1:0] funct;
	} instrFields;

	typedef enum logic [3:0] {
		clsAdd, clsAnd, clsSub, clsXor, clsSlt, clsBeq, clsBne, clsLw,
		clsSw, clsLui, clsJ, clsJr, clsJal, clsNop, clsBreak, clsIllegal
	} instrClass;

	typedef enum logic [2:0] {phReset, phFetch, phDecode, phExecute, phHalt} phaseType;

	typedef struct packed {
		phaseType phase;
		logic [stepIndexWidth-1:0] index;
	} stepType;

	typedef struct packed {
		logic memWrite;
		logic mdrLoad;
		logic pcWrite;
		logic pcCond;
		logic branchOnEqual;
		logic irWrite;
		logic aLoad;
		logic bLoad;
		logic aluOutLoad;
		logic regWrite;
		logic aluSrcA; // 0 pc, 1 reg A
		logic [aluSrcBWidth-1:0] aluSrcB;
		logic [aluOpWidth-1:0] aluOp;
		logic [regDstWidth-1:0] regDst;
		logic [regSourceWidth-1:0] regSource;
		logic [pcSourceWidth-1:0] pcSource;
		logic [addrSourceWidth-1:0] addrSource;
	} ctrlWord;

	typedef struct packed {
		logic lastStep;
		logic halt;
	} seqFlags;

endpackage

`default_nettype wire

/* hdl/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input ctrlPkg::instrFields instr,
	output ctrlPkg::instrClass cls
);
	import ctrlPkg::*;

	always_comb
	begin
		case (instr.opcode)
			opRType:
			begin
				case (instr.funct)
					fnAdd: cls = clsAdd;
					fnAnd: cls = clsAnd;
					fnSub: cls = clsSub;
					fnXor: cls = clsXor;
					fnSlt: cls = clsSlt;
					fnJr: cls = clsJr;
					fnBreak: cls = clsBreak;
					fnNop: cls = clsNop;
					default: cls = clsIllegal; // shifts land here too
				endcase
			end
			opBeq: cls = clsBeq;
			opBne: cls = clsBne;
			opLw: cls = clsLw;
			opSw: cls = clsSw;
			opLui: cls = clsLui;
			opJ: cls = clsJ;
			opJal: cls = clsJal;
			default: cls = clsIllegal;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/stepSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stepSequencer (
	input logic clk,
	input logic reset,
	input ctrlPkg::seqFlags flags,
	output ctrlPkg::stepType step,
	output logic halted
);
	import ctrlPkg::*;

	localparam logic [stepIndexWidth-1:0] lastFetch = stepIndexWidth'(fetchSteps - 1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			step.phase <= phReset;
			step.index <= '0;
		end
		else
		begin
			case (step.phase)
				phReset:
				begin
					step.phase <= phFetch;
					step.index <= '0;
				end
				phFetch:
				begin
					if (step.index == lastFetch)
					begin
						step.phase <= phDecode;
						step.index <= '0;
					end
					else
						step.index <= step.index + stepIndexWidth'(1);
				end
				phDecode:
				begin
					step.phase <= flags.halt ? phHalt : phExecute;
					step.index <= '0;
				end
				phExecute:
				begin
					if (flags.lastStep)
					begin
						step.phase <= phFetch; // next instruction
						step.index <= '0;
					end
					else
						step.index <= step.index + stepIndexWidth'(1);
				end
				phHalt: ; // held until reset
				default:
				begin
					step.phase <= phReset;
					step.index <= '0;
				end
			endcase
		end
	end

	assign halted = (step.phase == phHalt);

endmodule

`default_nettype wire

/* hdl/ctrlWordGen.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlWordGen (
	input ctrlPkg::instrClass cls,
	input ctrlPkg::stepType step,
	input logic lessThan,
	output ctrlPkg::ctrlWord ctrl,
	output ctrlPkg::seqFlags flags
);
	import ctrlPkg::*;

	logic [aluOpWidth-1:0] rTypeOp;
	logic [stepIndexWidth-1:0] lastIndex;

	always_comb
	begin
		case (cls)
			clsAnd: rTypeOp = aluAnd;
			clsSub: rTypeOp = aluSub;
			clsXor: rTypeOp = aluXor;
			default: rTypeOp = aluAdd;
		endcase
	end

	// final execute index per class
	always_comb
	begin
		case (cls)
			clsAdd, clsAnd, clsSub, clsXor: lastIndex = stepIndexWidth'(aluExecSteps - 1);
			clsSlt: lastIndex = stepIndexWidth'(sltExecSteps - 1);
			clsBeq, clsBne: lastIndex = stepIndexWidth'(branchExecSteps - 1);
			clsLw: lastIndex = stepIndexWidth'(lwExecSteps - 1);
			clsSw: lastIndex = stepIndexWidth'(swExecSteps - 1);
			clsLui: lastIndex = stepIndexWidth'(luiExecSteps - 1);
			clsJ, clsJr: lastIndex = stepIndexWidth'(jumpExecSteps - 1);
			clsJal: lastIndex = stepIndexWidth'(jalExecSteps - 1);
			default: lastIndex = stepIndexWidth'(nopExecSteps - 1);
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		flags.halt = 1'b0;
		flags.lastStep = (step.phase == phExecute) && (step.index == lastIndex);
		case (step.phase)
			phFetch:
			begin
				ctrl.addrSource = addrFromPc;
				ctrl.aluSrcB = srcBFour; // pc + 4
				ctrl.aluOp = aluAdd;
				ctrl.irWrite = 1'b1;
				if (step.index == stepIndexWidth'(fetchSteps - 1))
				begin
					ctrl.pcWrite = 1'b1;
					ctrl.pcSource = pcFromAlu;
				end
			end
			phDecode:
			begin
				ctrl.aluSrcB = srcBBranch; // branch target into aluOut
				ctrl.aluOp = aluAdd;
				ctrl.aLoad = 1'b1;
				ctrl.bLoad = 1'b1;
				ctrl.aluOutLoad = 1'b1;
				flags.halt = (cls == clsBreak) || (cls == clsIllegal);
			end
			phExecute:
			begin
				case (cls)
					clsAdd, clsAnd, clsSub, clsXor:
					begin
						ctrl.aluSrcA = 1'b1;
						ctrl.aluSrcB = srcBReg;
						ctrl.aluOp = rTypeOp;
						ctrl.aluOutLoad = (step.index == stepIndexWidth'(0));
						ctrl.regWrite = (step.index == stepIndexWidth'(1));
						ctrl.regDst = dstRd;
						ctrl.regSource = srcAluOut;
					end
					clsSlt:
					begin
						ctrl.aluSrcA = 1'b1;
						ctrl.aluSrcB = srcBReg;
						ctrl.aluOp = aluSlt;
						ctrl.regWrite = (step.index == stepIndexWidth'(1));
						ctrl.regDst = dstRd;
						ctrl.regSource = lessThan ? srcOne : srcZero;
					end
					clsBeq, clsBne:
					begin
						ctrl.aluSrcA = 1'b1;
						ctrl.aluSrcB = srcBReg;
						ctrl.aluOp = aluSub; // compare A and B
						ctrl.pcCond = 1'b1;
						ctrl.pcSource = pcFromAluOut;
						ctrl.branchOnEqual = (cls == clsBeq);
					end
					clsLw:
					begin
						ctrl.aluSrcA = 1'b1;
						ctrl.aluSrcB = srcBImm;
						ctrl.aluOp = aluAdd;
						ctrl.addrSource = addrFromAluOut;
						ctrl.aluOutLoad = (step.index == stepIndexWidth'(0));
						ctrl.mdrLoad = (step.index == stepIndexWidth'(3)); // after read and wait
						ctrl.regWrite = (step.index == stepIndexWidth'(4));
						ctrl.regDst = dstRt;
						ctrl.regSource = srcMemData;
					end
					clsSw:
					begin
						ctrl.aluSrcA = 1'b1;
						ctrl.aluSrcB = srcBImm;
						ctrl.aluOp = aluAdd;
						ctrl.addrSource = addrFromAluOut;
						ctrl.aluOutLoad = (step.index == stepIndexWidth'(0));
						ctrl.memWrite = (step.index != stepIndexWidth'(0)); // write held two cycles
					end
					clsLui:
					begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst = dstRt;
						ctrl.regSource = srcUpperImm;
					end
					clsJ:
					begin
						ctrl.pcWrite = 1'b1;
						ctrl.pcSource = pcFromJump;
					end
					clsJr:
					begin
						ctrl.pcWrite = 1'b1;
						ctrl.pcSource = pcFromReg;
					end
					clsJal:
					begin
						ctrl.aluOp = aluPass;
						ctrl.regWrite = (step.index == stepIndexWidth'(0)); // link first
						ctrl.regDst = dstRa;
						ctrl.regSource = srcReturnAddr;
						ctrl.pcWrite = (step.index == stepIndexWidth'(1));
						ctrl.pcSource = pcFromJump;
					end
					default: ; // nop, nothing to drive
				endcase
			end
			default: ; // reset and halt stay idle
		endcase
	end

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic clk,
	input logic reset,
	input ctrlPkg::instrFields instr,
	input logic lessThan,
	output ctrlPkg::ctrlWord ctrl,
	output ctrlPkg::stepType step,
	output logic halted
);
	import ctrlPkg::*;

	instrClass cls;
	seqFlags flags;

	instrDecoder i_instrDecoder (
		.instr(instr),
		.cls(cls)
	);

	stepSequencer i_stepSequencer (
		.clk(clk),
		.reset(reset),
		.flags(flags),
		.step(step),
		.halted(halted)
	);

	ctrlWordGen i_ctrlWordGen (
		.cls(cls),
		.step(step),
		.lessThan(lessThan),
		.ctrl(ctrl),
		.flags(flags)
	);

endmodule

`default_nettype wire

/* bench/ctrlMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlMonitor (
	input logic clk,
	input logic reset,
	input ctrlPkg::ctrlWord ctrl,
	input ctrlPkg::stepType step,
	input logic halted,
	input logic start,
	input logic [95:0] expected,
	input logic [7:0] patternNum,
	output int errorCount,
	output int checkCount
);
	import ctrlPkg::*;

	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] funct;
		logic [7:0] lessThan;
		logic [7:0] cycles;
		logic [7:0] regWrites;
		logic [7:0] regDst;
		logic [7:0] regSource;
		logic [7:0] memWrites;
		logic [7:0] jumpSrc; // ff when no jump
		logic [7:0] pcConds;
		logic [7:0] branchEq;
		logic [7:0] halt;
	} expectRec;

	expectRec rec = '0;
	logic [7:0] curNum = '0;
	logic armed = 1'b0; // record latched for the running instruction
	logic inWindow = 1'b0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int regWrites = 0;
	int memWrites = 0;
	int fetchPcWrites = 0;
	int execPcWrites = 0;
	int pcConds = 0;
	logic [7:0] seenRegDst = '0;
	logic [7:0] seenRegSource = '0;
	logic [7:0] seenJumpSrc = '0;
	logic [7:0] seenCondSrc = '0;
	logic [7:0] seenBranchEq = '0;

	assign errorCount = errors;
	assign checkCount = checks;

	function automatic string patternName();
		return $sformatf("pattern %0d (op %02h fn %02h)", curNum, rec.opcode, rec.funct);
	endfunction

	task automatic compare(input string what, input int expVal, input int actVal);
		checks++;
		if (expVal != actVal)
		begin
			errors++;
			$display("FAILED %s: %s expected %0h actual %0h", patternName(), what, expVal, actVal);
		end
	endtask

	task automatic report(input string msg);
		checks++;
		errors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic clearCounts();
		cycles = 0;
		regWrites = 0;
		memWrites = 0;
		fetchPcWrites = 0;
		execPcWrites = 0;
		pcConds = 0;
	endtask

	task automatic accumulate();
		cycles++;
		if (ctrl.regWrite)
		begin
			regWrites++;
			seenRegDst = 8'(ctrl.regDst);
			seenRegSource = 8'(ctrl.regSource);
		end
		if (ctrl.memWrite)
			memWrites++;
		if (ctrl.pcWrite && step.phase == phFetch)
			fetchPcWrites++;
		else if (ctrl.pcWrite)
		begin
			execPcWrites++;
			seenJumpSrc = 8'(ctrl.pcSource);
		end
		if (ctrl.pcCond)
		begin
			pcConds++;
			seenCondSrc = 8'(ctrl.pcSource);
			seenBranchEq = 8'(ctrl.branchOnEqual);
		end
	endtask

	task automatic finishInstr(input logic wasHalt);
		if (wasHalt && !rec.halt[0])
			report($sformatf("%s: unit halted on an instruction that should run", patternName()));
		else if (!wasHalt && rec.halt[0])
			report($sformatf("%s: unit fetched again instead of halting", patternName()));
		else
		begin
			compare("cycles", int'(rec.cycles), cycles);
			compare("regWrite count", int'(rec.regWrites), regWrites);
			if (rec.regWrites != '0)
			begin
				compare("regDst", int'(rec.regDst), int'(seenRegDst));
				compare("regSource", int'(rec.regSource), int'(seenRegSource));
			end
			compare("memWrite count", int'(rec.memWrites), memWrites);
			compare("fetch pcWrite count", 1, fetchPcWrites);
			compare("execute pcWrite count", (rec.jumpSrc != 8'hff) ? 1 : 0, execPcWrites);
			if (rec.jumpSrc != 8'hff)
				compare("jump pcSource", int'(rec.jumpSrc), int'(seenJumpSrc));
			compare("pcCond count", int'(rec.pcConds), pcConds);
			if (rec.pcConds != '0)
			begin
				compare("branch pcSource", int'(pcFromAluOut), int'(seenCondSrc));
				compare("branchOnEqual", int'(rec.branchEq), int'(seenBranchEq));
			end
		end
	endtask

	always @(negedge clk)
	begin
		if (reset || step.phase == phReset)
		begin
			checks++;
			if (ctrl.memWrite || ctrl.regWrite || ctrl.pcWrite || ctrl.pcCond || ctrl.mdrLoad)
				report("write control active during reset");
			if (halted)
				report("halted still set during reset");
			armed = 1'b0;
			inWindow = 1'b0;
		end
		else
		begin
			if (step.phase == phFetch && step.index == '0)
			begin
				if (armed)
					finishInstr(1'b0);
				clearCounts();
				armed = 1'b0;
				inWindow = 1'b1; // window opens at fetch index 0
			end
			if (start)
			begin
				rec = expectRec'(expected);
				curNum = patternNum;
				armed = 1'b1;
			end
			if (halted)
			begin
				if (armed)
					finishInstr(1'b1); // first halted cycle
				armed = 1'b0;
				inWindow = 1'b0;
				if (ctrl.pcWrite || ctrl.regWrite)
					report("pcWrite or regWrite asserted while halted");
			end
			else if (inWindow)
				accumulate();
		end
	end

endmodule

`default_nettype wire

/* bench/controlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
	import ctrlPkg::*;

	localparam int patternCount = 20;
	localparam int fieldCount = 12; // bytes per pattern line
	localparam int waitLimit = 40; // cycles per wait
	localparam int haltHold = 20; // cycles watched after a halt

	logic clk;
	logic reset;
	instrFields instr;
	logic lessThan;
	ctrlWord ctrl;
	stepType step;
	logic halted;

	logic start;
	logic [8*fieldCount-1:0] expected;
	logic [7:0] patternNum;
	int errorCount;
	int checkCount;
	logic timedOut;

	logic [7:0] patterns [0:patternCount*fieldCount-1];

	controlUnit i_controlUnit (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.lessThan(lessThan),
		.ctrl(ctrl),
		.step(step),
		.halted(halted)
	);

	ctrlMonitor i_ctrlMonitor (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.step(step),
		.halted(halted),
		.start(start),
		.expected(expected),
		.patternNum(patternNum),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [8*fieldCount-1:0] packRecord(input int base);
		logic [8*fieldCount-1:0] rec;
		rec = '0;
		for (int i = 0; i < fieldCount; i++)
			rec = {rec[8*fieldCount-9:0], patterns[base + i]}; // first column ends up on top
		return rec;
	endfunction

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	endtask

	// returns at the next fetch index 0 or at the first halted cycle
	task automatic waitBoundary(output logic sawHalt);
		int cycles;
		cycles = 0;
		sawHalt = 1'b0;
		if (!timedOut)
		begin
			@(negedge clk);
			while (!(step.phase == phFetch && step.index == '0) && !halted
				&& cycles < waitLimit)
			begin
				@(negedge clk);
				cycles++;
			end
			sawHalt = halted;
			if (cycles >= waitLimit)
			begin
				$display("ERROR: timeout waiting for the next fetch or for halt");
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic driveInstr(input int n);
		int base;
		base = n * fieldCount;
		@(posedge clk);
		instr.opcode <= patterns[base][5:0];
		instr.funct <= patterns[base + 1][5:0];
		lessThan <= patterns[base + 2][0];
		expected <= packRecord(base);
		patternNum <= 8'(n);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	initial
	begin
		logic sawHalt;
		reset = 1'b1;
		instr = '0;
		lessThan = 1'b0;
		start = 1'b0;
		expected = '0;
		patternNum = '0;
		timedOut = 1'b0;
		$readmemh("bench/instrPatterns.txt", patterns);
		applyReset();
		for (int n = 0; n < patternCount && !timedOut; n++)
		begin
			waitBoundary(sawHalt);
			if (sawHalt)
			begin
				repeat (haltHold) @(negedge clk); // monitor watches for stray writes
				applyReset();
				waitBoundary(sawHalt);
			end
			if (!timedOut)
				driveInstr(n);
		end
		waitBoundary(sawHalt); // closes the last instruction
		repeat (2) @(negedge clk);
		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timedOut);
		if (errorCount == 0 && !timedOut)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/instrPatterns.txt */
// opcode funct lessThan cycles regWrites regDst regSource memWrites
// jumpSrc(ff none) pcConds branchEq halt, all hex
00 20 0 06 1 1 0 0 ff 0 0 0
00 24 0 06 1 1 0 0 ff 0 0 0
00 22 1 06 1 1 0 0 ff 0 0 0
00 26 0 06 1 1 0 0 ff 0 0 0
00 2a 1 06 1 1 4 0 ff 0 0 0
00 2a 0 06 1 1 3 0 ff 0 0 0
04 00 0 05 0 0 0 0 ff 1 1 0
05 00 1 05 0 0 0 0 ff 1 0 0
23 00 0 09 1 0 1 0 ff 0 0 0
2b 00 0 07 0 0 0 2 ff 0 0 0
0f 00 0 05 1 0 2 0 ff 0 0 0
02 00 0 05 0 0 0 0 02 0 0 0
00 08 0 05 0 0 0 0 03 0 0 0
03 00 0 06 1 2 6 0 02 0 0 0
00 00 0 05 0 0 0 0 ff 0 0 0
00 0d 0 04 0 0 0 0 ff 0 0 1
00 20 1 06 1 1 0 0 ff 0 0 0
3f 00 0 04 0 0 0 0 ff 0 0 1
00 03 0 04 0 0 0 0 ff 0 0 1
0f 00 0 05 1 0 2 0 ff 0 0 0

/* build.f */
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/stepSequencer.sv
hdl/ctrlWordGen.sv
hdl/controlUnit.sv
bench/ctrlMonitor.sv
bench/controlUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= controlUnitTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
